// ==== Makefile ====
TOP = dmg_bus_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/10ps \
		--top-module $(TOP) -f dmg_bus.f

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module $(TOP) -Mdir obj_dir -f dmg_bus.f
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir

// ==== design/bus_decoder.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "dmg_bus_cfg.svh"

module bus_decoder (
	input  logic                   clk,
	input  logic                   rst,
	input  dmg_bus_pkg::cpu_addr_t addr,
	input  dmg_bus_pkg::cpu_data_t wr_data,
	input  logic                   rd,
	input  logic                   wr,
	output logic                   io_page,
	output logic                   hram_cs,
	output logic                   timer_cs,
	output logic                   boot_cs,
	output logic                   boot_off,
	output dmg_bus_pkg::bank_sel_t bank_sel,
	output dmg_bus_pkg::hram_off_t bank_off,
	output logic                   hram_wr,
	output logic                   hram_rd,
	output logic                   if_wr,
	output logic                   ie_wr,
	output dmg_bus_pkg::rd_src_e   rd_src
);

	import dmg_bus_pkg::*;

	logic [HRAM_BANK_W-1:0] bank_idx;
	logic                   boot_reg_hit;

	assign io_page  = (addr[15:8] == 8'hFF);
	assign hram_cs  = (addr >= `DMG_ADDR_HRAM_LO) && (addr <= `DMG_ADDR_HRAM_HI);
	assign timer_cs = (addr >= `DMG_ADDR_TIMER_LO) && (addr <= `DMG_ADDR_TIMER_HI);

	// the boot ROM overlays the bottom page until software turns it off
	assign boot_cs = rd && !boot_off && (addr <= `DMG_ADDR_BOOT_HI);

	// upper offset bits pick the bank and the rest address the byte inside it
	assign bank_idx = addr[6 -: HRAM_BANK_W];
	assign bank_off = addr[HRAM_OFF_W-1:0];

	always_comb begin
		bank_sel = '0;
		if (hram_cs) begin
			bank_sel[bank_idx] = 1'b1;
		end
	end

	assign hram_wr = hram_cs && wr;
	assign hram_rd = hram_cs && rd;

	assign if_wr = wr && (addr == `DMG_ADDR_IF);
	assign ie_wr = wr && (addr == `DMG_ADDR_IE);

	assign boot_reg_hit = (addr == `DMG_ADDR_BOOT_OFF);

	// only bit 0 of the written byte matters, and once set it stays set
	always_ff @(posedge clk) begin
		if (rst) begin
			boot_off <= 1'b0;
		end else if (wr && boot_reg_hit && wr_data[0]) begin
			boot_off <= 1'b1;
		end
	end

	// single registers win over the ranges they sit in
	always_comb begin
		if (addr == `DMG_ADDR_IF) begin
			rd_src = src_iflag;
		end else if (addr == `DMG_ADDR_IE) begin
			rd_src = src_ienable;
		end else if (boot_reg_hit) begin
			rd_src = src_boot_reg;
		end else if (hram_cs) begin
			rd_src = src_hram;
		end else if (io_page) begin
			rd_src = src_ones;
		end else begin
			rd_src = src_ext;
		end
	end

	bank_sel_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0(bank_sel));

endmodule

`default_nettype wire

// ==== design/dmg_bus.sv ====
`default_nettype none
`timescale 1ns/10ps

module dmg_bus (
	input  logic                   clk,
	input  logic                   rst,
	input  dmg_bus_pkg::cpu_addr_t addr,
	input  dmg_bus_pkg::cpu_data_t wr_data,
	input  logic                   rd,
	input  logic                   wr,
	input  dmg_bus_pkg::cpu_data_t ext_data,
	input  dmg_bus_pkg::irq_t      irq_req,
	output dmg_bus_pkg::cpu_data_t rd_data,
	output logic                   rd_valid,
	output logic                   io_page,
	output logic                   hram_cs,
	output logic                   timer_cs,
	output logic                   boot_cs,
	output logic                   irq_pending
);

	import dmg_bus_pkg::*;

	bank_sel_t bank_sel;
	hram_off_t bank_off;
	cpu_data_t bank_rdata [HRAM_BANKS];
	rd_src_e   rd_src;
	logic      hram_wr;
	logic      hram_rd;
	logic      if_wr;
	logic      ie_wr;
	logic      boot_off;

	bus_decoder bus_decoder_inst (
		.clk      (clk),
		.rst      (rst),
		.addr     (addr),
		.wr_data  (wr_data),
		.rd       (rd),
		.wr       (wr),
		.io_page  (io_page),
		.hram_cs  (hram_cs),
		.timer_cs (timer_cs),
		.boot_cs  (boot_cs),
		.boot_off (boot_off),
		.bank_sel (bank_sel),
		.bank_off (bank_off),
		.hram_wr  (hram_wr),
		.hram_rd  (hram_rd),
		.if_wr    (if_wr),
		.ie_wr    (ie_wr),
		.rd_src   (rd_src)
	);

	for (genvar i = 0; i < HRAM_BANKS; i++) begin : g_bank
		hram_bank hram_bank_inst (
			.clk   (clk),
			.sel   (bank_sel[i]),
			.off   (bank_off),
			.wr    (hram_wr),
			.rd    (hram_rd),
			.wdata (wr_data),
			.rdata (bank_rdata[i])
		);
	end

	io_read_port io_read_port_inst (
		.clk         (clk),
		.rst         (rst),
		.rd          (rd),
		.rd_src      (rd_src),
		.bank_sel    (bank_sel),
		.bank_rdata  (bank_rdata),
		.ext_data    (ext_data),
		.wr_data     (wr_data),
		.if_wr       (if_wr),
		.ie_wr       (ie_wr),
		.irq_req     (irq_req),
		.boot_off    (boot_off),
		.rd_data     (rd_data),
		.rd_valid    (rd_valid),
		.irq_pending (irq_pending)
	);

endmodule

`default_nettype wire

// ==== design/dmg_bus_cfg.svh ====
`ifndef DMG_BUS_CFG_SVH
`define DMG_BUS_CFG_SVH

// high RAM is split into 2, 4 or 8 banks
`define DMG_HRAM_BANKS 4

// single register addresses
`define DMG_ADDR_IF       16'hFF0F
`define DMG_ADDR_IE       16'hFFFF
`define DMG_ADDR_BOOT_OFF 16'hFF50

// region bounds include both ends
`define DMG_ADDR_HRAM_LO  16'hFF80
`define DMG_ADDR_HRAM_HI  16'hFFFE
`define DMG_ADDR_TIMER_LO 16'hFF04
`define DMG_ADDR_TIMER_HI 16'hFF07
`define DMG_ADDR_BOOT_HI  16'h00FF

`endif

// ==== design/dmg_bus_pkg.sv ====
`default_nettype none

`include "dmg_bus_cfg.svh"

package dmg_bus_pkg;

	localparam int HRAM_BANKS = `DMG_HRAM_BANKS;
	localparam int HRAM_BANK_W = $clog2(HRAM_BANKS);
	// high RAM spans 128 byte slots and the last one (FFFF) is never selected
	localparam int HRAM_DEPTH = 128 / HRAM_BANKS;
	localparam int HRAM_OFF_W = $clog2(HRAM_DEPTH);

	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0] cpu_data_t;
	typedef logic [HRAM_OFF_W-1:0] hram_off_t;
	typedef logic [HRAM_BANKS-1:0] bank_sel_t;
	typedef logic [4:0] irq_t;

	typedef enum logic [2:0] {
		src_ext,
		src_hram,
		src_iflag,
		src_ienable,
		src_boot_reg,
		src_ones
	} rd_src_e;

endpackage

`default_nettype wire

// ==== design/hram_bank.sv ====
`default_nettype none
`timescale 1ns/10ps

module hram_bank (
	input  logic                   clk,
	input  logic                   sel,
	input  dmg_bus_pkg::hram_off_t off,
	input  logic                   wr,
	input  logic                   rd,
	input  dmg_bus_pkg::cpu_data_t wdata,
	output dmg_bus_pkg::cpu_data_t rdata
);

	import dmg_bus_pkg::*;

	cpu_data_t mem [HRAM_DEPTH];

	always_ff @(posedge clk) begin
		if (sel && wr) begin
			mem[off] <= wdata;
		end
	end

	// rdata keeps the last byte read until the next read of this bank
	always_ff @(posedge clk) begin
		if (sel && rd) begin
			rdata <= mem[off];
		end
	end

endmodule

`default_nettype wire

// ==== design/io_read_port.sv ====
`default_nettype none
`timescale 1ns/10ps

module io_read_port (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   rd,
	input  dmg_bus_pkg::rd_src_e   rd_src,
	input  dmg_bus_pkg::bank_sel_t bank_sel,
	input  dmg_bus_pkg::cpu_data_t bank_rdata [dmg_bus_pkg::HRAM_BANKS],
	input  dmg_bus_pkg::cpu_data_t ext_data,
	input  dmg_bus_pkg::cpu_data_t wr_data,
	input  logic                   if_wr,
	input  logic                   ie_wr,
	input  dmg_bus_pkg::irq_t      irq_req,
	input  logic                   boot_off,
	output dmg_bus_pkg::cpu_data_t rd_data,
	output logic                   rd_valid,
	output logic                   irq_pending
);

	import dmg_bus_pkg::*;

	irq_t      iflag;
	cpu_data_t ienable;
	rd_src_e   src_q;
	bank_sel_t sel_q;
	cpu_data_t reg_byte;
	cpu_data_t reg_q;
	cpu_data_t hram_byte;

	// requests arriving with a write are merged after the written value
	always_ff @(posedge clk) begin
		if (rst) begin
			iflag       <= '0;
			ienable     <= '0;
			irq_pending <= 1'b0;
		end else begin
			if (if_wr) begin
				iflag <= wr_data[4:0] | irq_req;
			end else begin
				iflag <= iflag | irq_req;
			end
			if (ie_wr) begin
				ienable <= wr_data;
			end
			irq_pending <= |(iflag & ienable[4:0]);
		end
	end

	// everything except high RAM is captured as seen in the read cycle
	always_comb begin
		case (rd_src)
			src_iflag:    reg_byte = {3'b111, iflag};
			src_ienable:  reg_byte = ienable;
			src_boot_reg: reg_byte = {7'h7F, boot_off};
			src_ones:     reg_byte = 8'hFF;
			default:      reg_byte = ext_data;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= rd;
		end
	end

	always_ff @(posedge clk) begin
		if (rd) begin
			src_q <= rd_src;
			sel_q <= bank_sel;
			reg_q <= reg_byte;
		end
	end

	// banks register their own data, so pick it with the delayed select
	always_comb begin
		hram_byte = '0;
		for (int i = 0; i < HRAM_BANKS; i++) begin
			if (sel_q[i]) begin
				hram_byte = hram_byte | bank_rdata[i];
			end
		end
	end

	assign rd_data = (src_q == src_hram) ? hram_byte : reg_q;

	rd_valid_follows_rd: assert property (@(posedge clk) disable iff (rst)
		(rd_valid && $past(rd_valid)) |-> ($past(rd, 1) && $past(rd, 2)));

endmodule

`default_nettype wire

// ==== dmg_bus.f ====
+incdir+design
design/dmg_bus_pkg.sv
design/bus_decoder.sv
design/hram_bank.sv
design/io_read_port.sv
design/dmg_bus.sv
tests/dmg_bus_tb.sv

// ==== tests/dmg_bus_stim.txt ====
# name op addr data irq exp_rd hram_cs timer_cs boot_cs io_page irq_pending
# data is wr_data for W and ext_data for R, irq drives irq_req in that cycle
dec_boot_lo    R 0000 3c 00 3c 0 0 1 0 0
dec_boot_hi    R 00ff 5a 00 5a 0 0 1 0 0
dec_ext        R 0100 a5 00 a5 0 0 0 0 0
dec_timer_lo   R ff04 00 00 ff 0 1 0 1 0
dec_timer_hi   R ff07 00 00 ff 0 1 0 1 0
dec_io_gap     R ff08 00 00 ff 0 0 0 1 0
hram_w0        W ff80 11 00 00 1 0 0 1 0
hram_w1        W ffa0 22 00 00 1 0 0 1 0
hram_w2        W ffc5 33 00 00 1 0 0 1 0
hram_w3        W fffe 44 00 00 1 0 0 1 0
hram_r0        R ff80 77 00 11 1 0 0 1 0
hram_r1        R ffa0 77 00 22 1 0 0 1 0
hram_r2        R ffc5 77 00 33 1 0 0 1 0
hram_r3        R fffe 77 00 44 1 0 0 1 0
dec_ie_addr    R ffff 77 00 00 0 0 0 1 0
irq_if_wr      W ff0f 01 04 00 0 0 0 1 0
irq_if_rd      R ff0f 00 00 e5 0 0 0 1 0
irq_ie_wr      W ffff 04 00 00 0 0 0 1 0
irq_ie_rd      R ffff 00 00 04 0 0 0 1 0
irq_pend       I 0000 00 00 00 0 0 0 0 1
irq_clr        W ff0f 00 00 00 0 0 0 1 1
irq_clr_rd     R ff0f 00 00 e0 0 0 0 1 1
irq_req_in     I 0000 00 04 00 0 0 0 0 0
irq_req_rd     R ff0f 00 00 e4 0 0 0 1 0
boot_reg_rd    R ff50 00 00 fe 0 0 0 1 1
boot_wr_clr    W ff50 fe 00 00 0 0 0 1 1
boot_still_on  R 0010 99 00 99 0 0 1 0 1
boot_wr_set    W ff50 01 00 00 0 0 0 1 1
boot_off_rd    R 0010 66 00 66 0 0 0 0 1
boot_reg_set   R ff50 00 00 ff 0 0 0 1 1
boot_off_hi    R 00ff 12 00 12 0 0 0 0 1

// ==== tests/dmg_bus_tb.sv ====
`default_nettype none
`timescale 1ns/10ps

module dmg_bus_tb;

	import dmg_bus_pkg::*;

	localparam int CLK_HALF = 4;

	logic      clk;
	logic      rst;
	cpu_addr_t addr;
	cpu_data_t wr_data;
	logic      rd;
	logic      wr;
	cpu_data_t ext_data;
	irq_t      irq_req;
	cpu_data_t rd_data;
	logic      rd_valid;
	logic      io_page;
	logic      hram_cs;
	logic      timer_cs;
	logic      boot_cs;
	logic      irq_pending;

	// t_flag packs the expected hram, timer, boot, io and pending flags
	string      t_name [$];
	string      t_op [$];
	cpu_addr_t  t_addr [$];
	cpu_data_t  t_data [$];
	irq_t       t_irq [$];
	cpu_data_t  t_exp [$];
	logic [4:0] t_flag [$];
	int         n_tests;
	logic       loaded;

	dmg_bus dmg_bus_inst (
		.clk         (clk),
		.rst         (rst),
		.addr        (addr),
		.wr_data     (wr_data),
		.rd          (rd),
		.wr          (wr),
		.ext_data    (ext_data),
		.irq_req     (irq_req),
		.rd_data     (rd_data),
		.rd_valid    (rd_valid),
		.io_page     (io_page),
		.hram_cs     (hram_cs),
		.timer_cs    (timer_cs),
		.boot_cs     (boot_cs),
		.irq_pending (irq_pending)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#CLK_HALF clk = ~clk;
		end
	end

	task automatic abort_run();
		$display("Something failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_data(input string name, input cpu_data_t exp, input cpu_data_t act);
		if (act !== exp) begin
			$display("Fail %s rd_data: expected %h, actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_sel(input string name, input string what, input logic exp,
		input logic act);
		if (act !== exp) begin
			$display("Fail %s %s: expected %b, actual %b", name, what, exp, act);
			abort_run();
		end
	endtask

	// a read issued in the previous cycle must show up now, and only then
	task automatic collect_read(input logic pending, input string name, input cpu_data_t exp);
		if (pending) begin
			if (rd_valid !== 1'b1) begin
				$display("rd_valid did not rise one cycle after the read of test %s", name);
				abort_run();
			end
			check_data(name, exp, rd_data);
		end else if (rd_valid !== 1'b0) begin
			$display("rd_valid is high although no read was issued before %s", name);
			abort_run();
		end
	endtask

	task automatic load_stim();
		int         fd;
		int         cnt;
		string      line;
		string      name;
		string      op;
		logic [15:0] a;
		logic [7:0] d;
		logic [4:0] q;
		logic [7:0] e;
		logic       sh;
		logic       st;
		logic       sb;
		logic       si;
		logic       sp;
		fd = $fopen("tests/dmg_bus_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open tests/dmg_bus_stim.txt");
			abort_run();
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 1 && line.getc(0) != "#") begin
				cnt = $sscanf(line, "%s %s %h %h %h %h %b %b %b %b %b",
					name, op, a, d, q, e, sh, st, sb, si, sp);
				if (cnt != 11 || !(op == "R" || op == "W" || op == "I")) begin
					$display("stimulus line could not be parsed: %s", line);
					abort_run();
				end
				t_name.push_back(name);
				t_op.push_back(op);
				t_addr.push_back(a);
				t_data.push_back(d);
				t_irq.push_back(q);
				t_exp.push_back(e);
				t_flag.push_back({sh, st, sb, si, sp});
			end
		end
		$fclose(fd);
	endtask

	initial begin : main_seq
		string      prev_name;
		cpu_data_t  prev_exp;
		logic       rd_open;
		logic [4:0] flag;
		rst = 1'b1;
		addr = 16'h0000;
		wr_data = 8'h00;
		rd = 1'b0;
		wr = 1'b0;
		ext_data = 8'h00;
		irq_req = 5'h00;
		loaded = 1'b0;
		rd_open = 1'b0;
		prev_name = "reset";
		prev_exp = 8'h00;
		load_stim();
		n_tests = t_name.size();
		loaded = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		for (int i = 0; i < n_tests; i++) begin
			@(posedge clk);
			#1;
			collect_read(rd_open, prev_name, prev_exp);
			addr = t_addr[i];
			rd = (t_op[i] == "R");
			wr = (t_op[i] == "W");
			wr_data = (t_op[i] == "W") ? t_data[i] : 8'h00;
			ext_data = (t_op[i] == "R") ? t_data[i] : 8'h00;
			irq_req = t_irq[i];
			#2;
			flag = t_flag[i];
			check_sel(t_name[i], "hram_cs", flag[4], hram_cs);
			check_sel(t_name[i], "timer_cs", flag[3], timer_cs);
			check_sel(t_name[i], "boot_cs", flag[2], boot_cs);
			check_sel(t_name[i], "io_page", flag[1], io_page);
			check_sel(t_name[i], "irq_pending", flag[0], irq_pending);
			rd_open = rd;
			prev_name = t_name[i];
			prev_exp = t_exp[i];
		end
		@(posedge clk);
		#1;
		collect_read(rd_open, prev_name, prev_exp);
		rd = 1'b0;
		wr = 1'b0;
		irq_req = 5'h00;
		@(posedge clk);
		#1;
		collect_read(1'b0, "idle", 8'h00);
		$display("Everything OK");
		$finish;
	end

	initial begin : watchdog
		wait (loaded === 1'b1);
		repeat (n_tests * 4 + 100) @(posedge clk);
		$display("watchdog expired before the stimulus was finished");
		abort_run();
	end

endmodule

`default_nettype wire
